//--- common/uart_pkg.sv
/*
 * Serial frame constants for the 8N1 link to the host.
 * One start bit, eight data bits LSB first, one stop bit, no parity.
 * The bit period is a whole number of clock cycles, set per instance.
 */
package uart_pkg;

    localparam int DATA_BITS = 8;               // Payload bits per frame
    localparam int FRAME_BITS = DATA_BITS + 2;  // Start + data + stop

    // Default bit period in clock cycles, overridden from the top level
    localparam int DEFAULT_CLOCKS_PER_BIT = 16;

endpackage

//--- common/move_pkg.sv
/*
 * Move fetch definitions shared by the control unit, memory and top level.
 * State encoding 0 to 6 is fixed, since state_debug exposes it on pins
 * and external debug tools decode these values.
 */
package move_pkg;

    // Control unit states, in sequence order
    typedef enum logic [2:0] {
        state_idle     = 3'd0,
        state_prepare  = 3'd1,
        state_transmit = 3'd2,
        state_receive  = 3'd3,
        state_store    = 3'd4,
        state_advance  = 3'd5,
        state_finish   = 3'd6
    } control_state_t;

    // One stored move, exactly one UART payload byte
    typedef logic [7:0] move_t;

    // Byte sent to the host to ask for a list of moves ('M')
    localparam move_t REQUEST_BYTE = 8'h4D;

    // Moves fetched per request unless the top level overrides it
    localparam int DEFAULT_MOVE_COUNT = 8;

endpackage

//--- common/byte_stream_if.sv
/*
 * Received byte stream with valid/ready handshake.
 * A byte moves on an edge with valid and ready both high.
 * error marks a bad stop bit; such a byte is accepted but not stored.
 */
`timescale 1ns/100ps

interface byte_stream_if ();
    import move_pkg::*;

    logic  valid;  // Byte on data is ready for transfer
    logic  ready;  // Sink takes the byte this edge
    move_t data;
    logic  error;  // Stop bit was low

    modport source  (output valid, output data, output error, input ready);
    modport sink    (input valid, input data, input error, output ready);
    modport monitor (input valid, input ready, input data, input error);

endinterface

//--- common/store_if.sv
/*
 * Commands from the control unit to the move memory.
 * clear, write and advance are single-cycle strobes.
 * last is high while the address points at the final move slot.
 */
`timescale 1ns/100ps

interface store_if ();

    logic clear;    // Reset the write address to 0
    logic write;    // Write current byte at the write address
    logic advance;  // Step the write address
    logic last;     // Write address is MOVE_COUNT-1

    modport control (output clear, output write, output advance, input last);
    modport memory  (input clear, input write, input advance, output last);

endinterface

//--- uart/uart_tx.sv
/*
 * 8N1 serializer, one frame per send_start pulse.
 * tx drops for the start bit on the edge that samples send_start.
 * A frame lasts FRAME_BITS*CLOCKS_PER_BIT cycles and send_done pulses
 * once as the stop bit ends. send_start is ignored while sending.
 */
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            send_start,
    input  move_pkg::move_t data,
    output logic            tx,
    output logic            send_done
);
    import uart_pkg::*;

    localparam int TIMER_WIDTH = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
    localparam int COUNT_WIDTH = $clog2(FRAME_BITS);

    logic                   active;     // Frame in progress
    logic [TIMER_WIDTH-1:0] bit_timer;  // Cycles into current bit
    logic [COUNT_WIDTH-1:0] bit_count;  // Bit now on the line, 0 = start
    logic [FRAME_BITS-2:0]  shift_reg;  // Bits still to send, stop bit on top
    logic                   bit_end;

    assign bit_end = (bit_timer == TIMER_WIDTH'(CLOCKS_PER_BIT - 1));

    // Control and line state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            bit_timer <= '0;
            bit_count <= '0;
            tx        <= 1'b1;  // Line idles high
            send_done <= 1'b0;
        end else begin
            send_done <= 1'b0;
            if (!active) begin
                if (send_start) begin
                    active    <= 1'b1;
                    tx        <= 1'b0;  // Start bit
                    bit_timer <= '0;
                    bit_count <= '0;
                end
            end else if (bit_end) begin
                bit_timer <= '0;
                if (bit_count == COUNT_WIDTH'(FRAME_BITS - 1)) begin
                    active    <= 1'b0;  // Stop bit done, tx already high
                    send_done <= 1'b1;
                end else begin
                    tx        <= shift_reg[0];
                    bit_count <= bit_count + 1'b1;
                end
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
        end
    end

    // Payload shifter, LSB first, fills with idle ones
    always_ff @(posedge clock) begin
        if (!active && send_start) begin
            shift_reg <= {1'b1, data};
        end else if (active && bit_end) begin
            shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
        end
    end

endmodule

//--- uart/uart_rx.sv
/*
 * 8N1 deserializer with a two flip-flop input synchronizer.
 * Hunts for a falling edge, confirms the start bit at its middle and
 * samples every later bit at its middle. valid rises one cycle after the
 * middle of the stop bit and stays until the handshake; error is set when
 * the stop bit is low. No parity and no flow control.
 */
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          rx,
    byte_stream_if.source bytes
);
    import uart_pkg::*;

    localparam int TIMER_WIDTH = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
    localparam int COUNT_WIDTH = $clog2(DATA_BITS);
    localparam int HALF_BIT = (CLOCKS_PER_BIT > 1) ? CLOCKS_PER_BIT / 2 : 1;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta, rx_sync, rx_prev;  // Synchronizer and edge detect
    logic [TIMER_WIDTH-1:0] bit_timer;
    logic [COUNT_WIDTH-1:0] bit_count;
    logic [DATA_BITS-1:0]   shift_reg;
    logic                   bit_end;
    logic                   half_end;

    assign bit_end  = (bit_timer == TIMER_WIDTH'(CLOCKS_PER_BIT - 1));
    assign half_end = (bit_timer == TIMER_WIDTH'(HALF_BIT - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Frame sequencer and valid flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= rx_idle;
            bit_timer   <= '0;
            bit_count   <= '0;
            bytes.valid <= 1'b0;
        end else begin
            if (bytes.valid && bytes.ready) begin
                bytes.valid <= 1'b0;  // Handshake done
            end
            case (state)
                rx_idle: begin
                    bit_timer <= '0;
                    if (rx_prev && !rx_sync) begin  // Falling edge only
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (half_end) begin
                        bit_timer <= '0;
                        bit_count <= '0;
                        state     <= rx_sync ? rx_idle : rx_data;  // Glitch check
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        bit_timer <= '0;
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == COUNT_WIDTH'(DATA_BITS - 1)) begin
                            state <= rx_stop;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        bit_timer   <= '0;
                        bytes.valid <= 1'b1;
                        state       <= rx_idle;  // Next frame needs a new falling edge
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Payload path, shifted in LSB first and latched at mid stop bit
    always_ff @(posedge clock) begin
        if (state == rx_data && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (state == rx_stop && bit_end) begin
            bytes.data  <= shift_reg;
            bytes.error <= !rx_sync;  // Framing error
        end
    end

endmodule

//--- source/move_receive_control.sv
/*
 * Central FSM for one move fetch: request, then receive and store
 * until the memory reports its last slot, then pulse done.
 * start is only seen in idle. Bytes with a framing error are taken
 * off the stream and dropped without using an address.
 */
`timescale 1ns/100ps

module move_receive_control (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  send_done,
    output logic                  send_start,
    byte_stream_if.sink           bytes,
    store_if.control              store,
    output logic                  done,
    output logic                  busy,
    output logic [2:0]            state_debug
);
    import move_pkg::*;

    control_state_t state, next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            state_idle:     if (start) next_state = state_prepare;
            state_prepare:  next_state = state_transmit;  // Request goes out now
            state_transmit: if (send_done) next_state = state_receive;
            state_receive: begin
                if (bytes.valid) begin  // ready is high here, so this is the handshake
                    next_state = bytes.error ? state_receive : state_store;
                end
            end
            state_store:    next_state = state_advance;
            state_advance:  next_state = store.last ? state_finish : state_receive;
            state_finish:   next_state = state_idle;
            default:        next_state = state_idle;
        endcase
    end

    // Moore outputs, decoded straight from the state
    assign send_start    = (state == state_prepare);
    assign store.clear   = (state == state_prepare);   // New run starts at address 0
    assign bytes.ready   = (state == state_receive);
    assign store.write   = (state == state_store);
    assign store.advance = (state == state_advance);
    assign done          = (state == state_finish);
    assign busy          = (state != state_idle) && (state != state_finish);
    assign state_debug   = state;  // Raw encoding for debug pins

endmodule

//--- source/move_store.sv
/*
 * Move memory with its write address counter.
 * The address clears on clear, steps on advance and holds at the last
 * slot. Writes take the byte held on the stream. The read port is
 * registered, so read_data follows read_addr by one cycle.
 */
`timescale 1ns/100ps

module move_store #(
    parameter int  MOVE_COUNT = move_pkg::DEFAULT_MOVE_COUNT,
    localparam int ADDR_WIDTH = (MOVE_COUNT > 1) ? $clog2(MOVE_COUNT) : 1
) (
    input  logic                  clock,
    input  logic                  reset,
    store_if.memory               store,
    byte_stream_if.monitor        bytes,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output move_pkg::move_t       read_data
);
    import move_pkg::*;

    move_t                 memory [MOVE_COUNT];
    logic [ADDR_WIDTH-1:0] write_addr;

    assign store.last = (write_addr == ADDR_WIDTH'(MOVE_COUNT - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_addr <= '0;
        end else if (store.clear) begin
            write_addr <= '0;
        end else if (store.advance && !store.last) begin  // Stays in range
            write_addr <= write_addr + 1'b1;
        end
    end

    // Data is still held by the receiver in the cycle after the handshake
    always_ff @(posedge clock) begin
        if (store.write) begin
            memory[write_addr] <= bytes.data;
        end
    end

    always_ff @(posedge clock) begin
        read_data <= memory[read_addr];
    end

endmodule

//--- source/move_receiver.sv
/*
 * Move fetch subsystem top level.
 * A start pulse in idle sends REQUEST_BYTE on tx, then MOVE_COUNT good
 * bytes from rx are stored and done pulses once. Moves are read back
 * through read_addr/read_data with one cycle of latency.
 * Both serial lines idle high and share one CLOCKS_PER_BIT.
 */
`timescale 1ns/100ps

module move_receiver #(
    parameter int  CLOCKS_PER_BIT = uart_pkg::DEFAULT_CLOCKS_PER_BIT,
    parameter int  MOVE_COUNT     = move_pkg::DEFAULT_MOVE_COUNT,
    localparam int ADDR_WIDTH     = (MOVE_COUNT > 1) ? $clog2(MOVE_COUNT) : 1
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  rx,
    output logic                  tx,
    output logic                  done,
    output logic                  busy,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output move_pkg::move_t       read_data,
    output logic [2:0]            state_debug
);
    import move_pkg::*;

    logic send_start;  // Control to transmitter
    logic send_done;   // Transmitter back to control

    byte_stream_if bytes_bus ();
    store_if       store_bus ();

    uart_tx #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) u_uart_tx (
        .clock      (clock),
        .reset      (reset),
        .send_start (send_start),
        .data       (REQUEST_BYTE),
        .tx         (tx),
        .send_done  (send_done)
    );

    uart_rx #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) u_uart_rx (
        .clock (clock),
        .reset (reset),
        .rx    (rx),
        .bytes (bytes_bus.source)
    );

    move_receive_control u_control (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .send_done   (send_done),
        .send_start  (send_start),
        .bytes       (bytes_bus.sink),
        .store       (store_bus.control),
        .done        (done),
        .busy        (busy),
        .state_debug (state_debug)
    );

    move_store #(
        .MOVE_COUNT(MOVE_COUNT)
    ) u_store (
        .clock     (clock),
        .reset     (reset),
        .store     (store_bus.memory),
        .bytes     (bytes_bus.monitor),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

//--- sim/move_receiver_assertions.sv
/*
 * Concurrent checks on the move fetch control unit, bound into every
 * move_receive_control instance. All checks are off during reset.
 * Each check ties an output to the stream or memory events around it.
 */
`timescale 1ns/100ps

module move_receiver_assertions (
    input logic       clock,
    input logic       reset,
    input logic       done,
    input logic       busy,
    input logic       valid,
    input logic       ready,
    input logic       error,
    input logic       write,
    input logic       advance,
    input logic       last,
    input logic       send_start,
    input logic [2:0] state_debug
);
    import move_pkg::*;

    // done only follows a step at the final slot, and lasts one cycle
    done_after_last: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(advance) && $past(last) && state_debug == state_finish)
        else $error("done without a step at the last slot");

    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done && !busy)
        else $error("done stayed high or busy after done");

    // Good byte taken off the stream is written next, bad one is dropped
    good_byte_written: assert property (@(posedge clock) disable iff (reset)
        valid && ready && !error |=> write && !ready)
        else $error("good byte not written after handshake");

    bad_byte_dropped: assert property (@(posedge clock) disable iff (reset)
        valid && ready && error |=> ready && !write)
        else $error("byte with framing error was not dropped");

    write_apart_from_advance: assert property (@(posedge clock) disable iff (reset)
        write |=> advance && !write)
        else $error("write not followed by a single advance");

    // Request goes out only on leaving idle
    send_in_prepare: assert property (@(posedge clock) disable iff (reset)
        send_start |-> !$past(busy) && state_debug == state_prepare)
        else $error("send_start outside prepare");

endmodule

bind move_receive_control move_receiver_assertions u_assertions (
    .clock       (clock),
    .reset       (reset),
    .done        (done),
    .busy        (busy),
    .valid       (bytes.valid),
    .ready       (bytes.ready),
    .error       (bytes.error),
    .write       (store.write),
    .advance     (store.advance),
    .last        (store.last),
    .send_start  (send_start),
    .state_debug (state_debug)
);

//--- sim/tb_move_receiver.sv
/*
 * Testbench for move_receiver with a host UART model on rx and a
 * request decoder on tx. Bytes and corrupt flags come from
 * sim/move_vectors.txt, one run after another. A run ends when
 * MOVE_COUNT good bytes are sent. Inputs change on rising edges and
 * outputs are sampled on falling edges.
 */
`timescale 1ns/100ps

module tb_move_receiver;

    localparam int CLOCKS_PER_BIT = 8;
    localparam int MOVE_COUNT     = 8;
    localparam int ADDR_WIDTH     = $clog2(MOVE_COUNT);
    localparam int FRAME_BITS     = 10;      // Start, 8 data, stop
    localparam int RUNS           = 2;
    localparam int VECTOR_COUNT   = 19;      // Entries in the vector file
    localparam logic [7:0] REQUEST = 8'h4D;  // 'M' asks the host for moves
    // Every frame plus its longest gap, and slack for start and readback
    localparam int CYCLE_LIMIT = (VECTOR_COUNT + RUNS) * (FRAME_BITS + 5) * CLOCKS_PER_BIT + 600;

    logic                  clock, reset, start, rx, tx, done, busy;
    logic [ADDR_WIDTH-1:0] read_addr;
    logic [7:0]            read_data;
    logic [2:0]            state_debug;

    logic [11:0] vectors [VECTOR_COUNT];  // Flag in bit 8, move in 7:0
    logic [7:0]  expected [$];            // Good bytes of the current run
    int          next_vector;
    int          done_count = 0;
    int          cycle_count = 0;
    logic        request_window;          // tx may leave idle

    move_receiver #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
        .MOVE_COUNT    (MOVE_COUNT)
    ) dut (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .rx          (rx),
        .tx          (tx),
        .done        (done),
        .busy        (busy),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .state_debug (state_debug)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, done never came", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Done counter and idle check on tx between requests
    always @(negedge clock) begin
        if (done === 1'b1) done_count++;
        if (!reset && !request_window) begin
            assert (tx === 1'b1) else report_failure("tx left idle outside a request frame");
        end
    end

    task automatic report_failure(input string message);
        $display("FAIL at %0t ns: %s", $time, message);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    // Holds rx at value for the given number of cycles
    task automatic drive_bit(input logic value, input int cycles);
        @(posedge clock);
        rx <= value;
        repeat (cycles - 1) @(posedge clock);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic corrupt);
        drive_bit(1'b0, CLOCKS_PER_BIT);
        for (int i = 0; i < 8; i++) drive_bit(data[i], CLOCKS_PER_BIT);  // LSB first
        drive_bit(!corrupt, CLOCKS_PER_BIT);  // Low stop bit on a corrupt byte
    endtask

    // Decodes one frame from tx at bit middles and checks start timing
    task automatic check_request();
        int         wait_cycles;
        logic [7:0] value;
        wait_cycles = 0;
        while (tx !== 1'b0) begin
            @(negedge clock);
            wait_cycles++;
        end
        assert (wait_cycles == 2)
            else report_failure($sformatf("tx start bit %0d cycles after start", wait_cycles));
        repeat (CLOCKS_PER_BIT / 2) @(negedge clock);
        assert (tx === 1'b0 && busy === 1'b1)
            else report_failure("start bit or busy wrong during request");
        for (int i = 0; i < 8; i++) begin
            repeat (CLOCKS_PER_BIT) @(negedge clock);
            value[i] = tx;
        end
        repeat (CLOCKS_PER_BIT) @(negedge clock);
        assert (tx === 1'b1) else report_failure("request stop bit low");
        assert (value == REQUEST)
            else report_failure($sformatf("request %02h, expected %02h", value, REQUEST));
    endtask

    task automatic fetch_run(input int run);
        logic [11:0] entry;
        int          good;
        good = 0;
        expected.delete();
        @(posedge clock);
        start <= 1'b1;
        request_window = 1'b1;
        @(posedge clock);
        start <= 1'b0;
        check_request();
        request_window = 1'b0;
        while (good < MOVE_COUNT) begin
            assert (next_vector < VECTOR_COUNT) else report_failure("vector file ran out");
            entry = vectors[next_vector];
            next_vector++;
            drive_bit(1'b1, CLOCKS_PER_BIT + int'($urandom % (3 * CLOCKS_PER_BIT)));  // Gap
            assert (done_count == run) else report_failure("done before the last good byte");
            if (good == 1) begin  // Start while busy, no new request allowed
                start <= 1'b1;
                @(posedge clock);
                start <= 1'b0;
            end
            send_frame(entry[7:0], entry[8]);
            if (!entry[8]) begin
                expected.push_back(entry[7:0]);
                good++;
            end
        end
        while (done_count == run) @(posedge clock);
        repeat (2) @(posedge clock);
        assert (done_count == run + 1 && busy === 1'b0 && state_debug === 3'd0)
            else report_failure($sformatf("after done: count %0d busy %b state %0d",
                                          done_count, busy, state_debug));
        for (int a = 0; a < MOVE_COUNT; a++) begin
            @(posedge clock);
            read_addr <= ADDR_WIDTH'(a);
            @(posedge clock);  // Registered read
            @(negedge clock);
            assert (read_data === expected[a])
                else report_failure($sformatf("address %0d read %02h, expected %02h",
                                              a, read_data, expected[a]));
        end
    endtask

    initial begin
        void'($urandom(32'h163d_dfaf));
        $readmemh("sim/move_vectors.txt", vectors);
        reset          = 1'b1;
        start          = 1'b0;
        rx             = 1'b1;  // Line idles high
        read_addr      = '0;
        request_window = 1'b0;
        next_vector    = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (tx === 1'b1 && done === 1'b0 && busy === 1'b0 && state_debug === 3'd0)
            else report_failure("outputs wrong after reset");
        for (int run = 0; run < RUNS; run++) fetch_run(run);
        repeat (4 * CLOCKS_PER_BIT) @(posedge clock);  // Catch any late done
        if (done_count == RUNS) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("FAIL at %0t ns: done pulsed %0d times in %0d runs", $time, done_count, RUNS);
            $display("RESULT: FAIL");
            $fatal(1, "Done count mismatch");
        end
    end

endmodule

//--- sim/move_vectors.txt
// One entry per host byte: flag digit, then the move byte in hex
// Flag 1 sends the byte with a low stop bit; each run ends at 8 good bytes
// Run 1
0_3c
0_a5
1_ff
0_12
0_e7
0_40
0_9b
0_01
0_d8
// Run 2
1_55
0_c3
0_7e
0_00
1_81
0_6a
0_f0
0_2d
0_b4
0_19

//--- sim.f
common/uart_pkg.sv
common/move_pkg.sv
common/byte_stream_if.sv
common/store_if.sv
uart/uart_tx.sv
uart/uart_rx.sv
source/move_receive_control.sv
source/move_store.sv
source/move_receiver.sv
sim/move_receiver_assertions.sv
sim/tb_move_receiver.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f sim.f --top-module tb_move_receiver -o tb_move_receiver \
    || { echo "Build failed"; exit 1; }
output=$(./obj_dir/tb_move_receiver 2>&1)
echo "$output"
echo "$output" | grep -qx "RESULT: PASS" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
